// ==== vlog.f ====
+incdir+verification
logic/isaPkg.sv
logic/ctrlPkg.sv
logic/decodeIf.sv
logic/instrDecoder.sv
logic/stateSequencer.sv
logic/controlEncoder.sv
logic/mipsControl.sv
verification/clockGen.sv
verification/mipsControlTb.sv

// ==== Makefile ====
SOURCES := $(shell grep -v '^+' vlog.f) verification/refModel.svh
BIN     := obj_dir/VmipsControlTb

.PHONY: run clean

run: $(BIN)
	./$(BIN) | awk '{ print } /Test completed successfully/ { ok = 1 } END { exit !ok }'

$(BIN): vlog.f $(SOURCES)
	verilator --binary --assert --timescale 1ns/10ps --top-module mipsControlTb -f vlog.f

clean:
	rm -rf obj_dir

// ==== verification/refModel.svh ====
// Outputs expected while in one state, and the state that follows it
typedef struct packed {
    stateT     nextState;
    logic      pcWrite, pcWriteCond, irWrite, memRead;
    logic      memWrite, regWrite, mdrWrite, iOrD;
    aluOpT     aluOp;
    srcASelT   srcA;
    srcBSelT   srcB;
    regDstT    regDst;
    memToRegT  memToReg;
    pcSrcT     pcSrc;
    memRWidthT memRWidth;
    memWWidthT memWWidth;
} stepT;

function automatic instrClassT classify(instrT ins);
    case (ins[31:26])
        OpRtype:
        begin
            if (ins[5:0] == FunctJr || ins[5:0] == FunctJalr)
                return ClassJump;
            if (ins[5:0] inside {FunctSll, FunctSrl, FunctSra, FunctSllv, FunctSrlv, FunctSrav,
                                 FunctAdd, FunctAddu, FunctSub, FunctSubu, FunctAnd, FunctOr,
                                 FunctXor, FunctNor, FunctSlt, FunctSltu})
                return ClassAlu;
        end
        OpRegimm:
            if (ins[20:16] == RtBltz || ins[20:16] == RtBgez)
                return ClassBranch;
        OpJ, OpJal:                     return ClassJump;
        OpBeq, OpBne, OpBlez, OpBgtz:   return ClassBranch;
        OpLb, OpLh, OpLw, OpLbu, OpLhu: return ClassLoad;
        OpSb, OpSh, OpSw:               return ClassStore;
        OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui: return ClassAlu;
        default: ;
    endcase
    return ClassIllegal;
endfunction

function automatic stepT expectedStep(instrT ins, stateT st);
    stepT       s;
    instrClassT cls;
    opcodeT     op;
    functT      fn;
    cls = classify(ins);
    op  = ins[31:26];
    fn  = ins[5:0];
    s   = '0; // All inactive, back to Initial
    case (st)
        Initial: s.nextState = Fetch;
        Fetch:
        begin
            s.nextState = Decode;
            s.pcWrite   = 1'b1;
            s.irWrite   = 1'b1;
            s.srcA      = SrcAPc;
            s.srcB      = SrcBFour;
        end
        Decode:
        begin
            s.srcA = SrcAPc;
            s.srcB = SrcBBranchOff;
            case (cls)
                ClassAlu:              s.nextState = Execute;
                ClassLoad, ClassStore: s.nextState = MemAddr;
                ClassBranch:           s.nextState = Branch;
                ClassJump:             s.nextState = Jump;
                default: ;
            endcase
        end
        MemAddr:
        begin
            s.srcB = SrcBSignImm;
            if (cls == ClassLoad)
                s.nextState = MemLoad;
            else
                s.nextState = MemStore;
        end
        MemLoad:
        begin
            s.nextState = LoadWriteback;
            s.iOrD      = 1'b1;
            s.memRead   = 1'b1;
            s.mdrWrite  = 1'b1;
            case (op)
                OpLw:    s.memRWidth = RdWord;
                OpLh:    s.memRWidth = RdHalf;
                OpLhu:   s.memRWidth = RdHalfU;
                OpLb:    s.memRWidth = RdByte;
                default: s.memRWidth = RdByteU;
            endcase
        end
        MemStore:
        begin
            s.nextState = Fetch;
            s.iOrD      = 1'b1;
            s.memWrite  = 1'b1;
            case (op)
                OpSw:    s.memWWidth = WrWord;
                OpSh:    s.memWWidth = WrHalf;
                default: s.memWWidth = WrByte;
            endcase
        end
        Execute:
        begin
            s.nextState = AluWriteback;
            if (op == OpRtype)
            begin
                if (fn inside {FunctSll, FunctSrl, FunctSra})
                    s.srcA = SrcAShamt; // Shift amount from the instruction
                case (fn)
                    FunctSub, FunctSubu: s.aluOp = Sub;
                    FunctAnd:            s.aluOp = And;
                    FunctOr:             s.aluOp = Or;
                    FunctXor:            s.aluOp = Xor;
                    FunctNor:            s.aluOp = Nor;
                    FunctSlt:            s.aluOp = Slt;
                    FunctSltu:           s.aluOp = Sltu;
                    FunctSll, FunctSllv: s.aluOp = Sll;
                    FunctSrl, FunctSrlv: s.aluOp = Srl;
                    FunctSra, FunctSrav: s.aluOp = Sra;
                    default: ;
                endcase
            end
            else
            begin
                s.srcB = SrcBSignImm;
                case (op)
                    OpSlti:  s.aluOp = Slt;
                    OpSltiu: s.aluOp = Sltu;
                    OpAndi:  s.aluOp = AndI;
                    OpOri:   s.aluOp = OrI;
                    OpXori:  s.aluOp = XorI;
                    OpLui:   s.aluOp = Lui;
                    default: ;
                endcase
            end
        end
        AluWriteback:
        begin
            s.nextState = Fetch;
            s.regWrite  = 1'b1;
            s.memToReg  = WbAluOut;
            if (op == OpRtype)
                s.regDst = DstRd;
        end
        Branch:
        begin
            s.nextState   = Fetch;
            s.pcWriteCond = 1'b1;
            s.pcSrc       = PcBranchTarget;
            case (op)
                OpBeq:  s.aluOp = Sub;
                OpBne:  s.aluOp = Bne;
                OpBlez: s.aluOp = Blez;
                OpBgtz: s.aluOp = Bgtz;
                default:
                    if (ins[20:16] == RtBltz)
                        s.aluOp = Bltz;
                    else
                        s.aluOp = Bgez;
            endcase
        end
        Jump:
        begin
            s.nextState = Fetch;
            s.pcWrite   = 1'b1;
            if (op == OpRtype)
                s.pcSrc = PcRegister;
            else
                s.pcSrc = PcJumpTarget;
            if (op == OpJal || (op == OpRtype && fn == FunctJalr))
            begin
                s.regWrite = 1'b1;
                s.regDst   = DstLink;
                s.memToReg = WbPcPlus4;
            end
        end
        LoadWriteback:
        begin
            s.nextState = Fetch;
            s.regWrite  = 1'b1;
        end
        default: ;
    endcase
    return s;
endfunction

// Cycles from the Fetch of ins to the following Fetch
function automatic int fetchToFetch(instrT ins);
    stepT  s;
    stateT st;
    int    n;
    st = Fetch;
    n  = 0;
    do
    begin
        s  = expectedStep(ins, st);
        st = s.nextState;
        n++;
    end while (st != Fetch && n < 8);
    return n;
endfunction

// ==== verification/mipsControlTb.sv ====
`timescale 1ns/10ps

module mipsControlTb;
    import isaPkg::*;
    import ctrlPkg::*;

    `include "refModel.svh"

    localparam functT AluFuncts [16] = '{FunctAdd, FunctAddu, FunctSub, FunctSubu, FunctAnd,
        FunctOr, FunctXor, FunctNor, FunctSlt, FunctSltu, FunctSll, FunctSrl, FunctSra,
        FunctSllv, FunctSrlv, FunctSrav};

    logic      clk;
    logic      rstN;
    instrT     instr;
    stateT     state;
    logic      pcWrite, pcWriteCond, irWrite, memRead;
    logic      memWrite, regWrite, mdrWrite, iOrD;
    aluOpT     aluOp;
    srcASelT   srcA;
    srcBSelT   srcB;
    regDstT    regDst;
    memToRegT  memToReg;
    pcSrcT     pcSrc;
    memRWidthT memRWidth;
    memWWidthT memWWidth;

    string testName = "reset";
    int    errorCount = 0;
    int    checkCount = 0;
    int    testsPassed = 0;
    int    testsFailed = 0;
    instrT running; // Word latched at the last Fetch
    instrT wordList [$];
    stateT expState = Initial;
    instrT expInstr = '0;
    stepT  want;

    clockGen clockGen_i (.clk(clk));

    mipsControl dut_i (.*);

    task automatic checkValue(input string what, input logic [31:0] expected,
                              input logic [31:0] actual);
        checkCount++;
        if (expected !== actual)
        begin
            errorCount++;
            $display("** Error %s: %s expected %0d, actual %0d", testName, what, expected, actual);
        end
    endtask

    // Outputs are stable mid-cycle
    always @(negedge clk)
    begin
        want = expectedStep(expInstr, expState);
        checkValue("state", 32'(expState), 32'(state));
        checkValue("pcWrite", 32'(want.pcWrite), 32'(pcWrite));
        checkValue("pcWriteCond", 32'(want.pcWriteCond), 32'(pcWriteCond));
        checkValue("irWrite", 32'(want.irWrite), 32'(irWrite));
        checkValue("memRead", 32'(want.memRead), 32'(memRead));
        checkValue("memWrite", 32'(want.memWrite), 32'(memWrite));
        checkValue("regWrite", 32'(want.regWrite), 32'(regWrite));
        checkValue("mdrWrite", 32'(want.mdrWrite), 32'(mdrWrite));
        checkValue("iOrD", 32'(want.iOrD), 32'(iOrD));
        checkValue("aluOp", 32'(want.aluOp), 32'(aluOp));
        checkValue("srcA", 32'(want.srcA), 32'(srcA));
        checkValue("srcB", 32'(want.srcB), 32'(srcB));
        checkValue("regDst", 32'(want.regDst), 32'(regDst));
        checkValue("memToReg", 32'(want.memToReg), 32'(memToReg));
        checkValue("pcSrc", 32'(want.pcSrc), 32'(pcSrc));
        checkValue("memRWidth", 32'(want.memRWidth), 32'(memRWidth));
        checkValue("memWWidth", 32'(want.memWWidth), 32'(memWWidth));
        if (!rstN)
            expState = Initial;
        else
        begin
            if (want.nextState == Fetch)
                expInstr = instr; // Held through the coming edge
            expState = want.nextState;
        end
    end

    task automatic awaitFetch(input int expectCycles);
        int cycles;
        cycles = 0;
        do
        begin
            @(posedge clk);
            #10;
            cycles++;
        end while (state != Fetch && cycles < 20);
        if (state != Fetch)
        begin
            $display("Timeout: state never returned to Fetch in test %s", testName);
            $display("Test failed");
            $finish;
        end
        else
        begin
            checkValue("cycles", expectCycles, cycles);
            running = instr;
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        if (errorCount == errorsBefore)
        begin
            testsPassed++;
            $display("PASS  %s", name);
        end
        else
        begin
            testsFailed++;
            $display("FAIL  %s: %0d mismatches", name, errorCount - errorsBefore);
        end
    endtask

    task automatic runTest(input string name);
        int errorsBefore;
        errorsBefore = errorCount;
        testName     = name;
        foreach (wordList[i])
        begin
            instr = wordList[i]; // Latched at the next Fetch entry
            awaitFetch(fetchToFetch(running));
        end
        awaitFetch(fetchToFetch(running)); // Last word runs to its end
        wordList.delete();
        finishTest(name, errorsBefore);
    endtask

    function automatic instrT rType(functT fn);
        return {OpRtype, 5'd1, 5'd2, 5'd3, 5'd4, fn};
    endfunction

    function automatic instrT iType(opcodeT op, regIdxT rt);
        return {op, 5'd5, rt, 16'h1234};
    endfunction

    initial
    begin
        instrT word;
        void'($urandom(79562));
        rstN  = 1'b0;
        instr = iType(OpAddiu, 5'd1);
        repeat (5) @(posedge clk);
        #10;
        rstN = 1'b1;
        awaitFetch(1); // One Initial cycle after release
        finishTest("reset", 0);

        foreach (AluFuncts[i])
            wordList.push_back(rType(AluFuncts[i]));
        for (int op = 8; op < 16; op++)
            wordList.push_back(iType(6'(op), 5'd2)); // addi through lui
        runTest("alu ops");

        wordList.push_back(iType(OpLw, 5'd6));
        wordList.push_back(iType(OpLh, 5'd6));
        wordList.push_back(iType(OpLhu, 5'd6));
        wordList.push_back(iType(OpLb, 5'd6));
        wordList.push_back(iType(OpLbu, 5'd6));
        wordList.push_back(iType(OpSw, 5'd7));
        wordList.push_back(iType(OpSh, 5'd7));
        wordList.push_back(iType(OpSb, 5'd7));
        runTest("loads and stores");

        wordList.push_back(iType(OpBeq, 5'd3));
        wordList.push_back(iType(OpBne, 5'd3));
        wordList.push_back(iType(OpBlez, 5'd0));
        wordList.push_back(iType(OpBgtz, 5'd0));
        wordList.push_back(iType(OpRegimm, RtBltz));
        wordList.push_back(iType(OpRegimm, RtBgez));
        runTest("branches");

        wordList.push_back({OpJ, 26'h0123456});
        wordList.push_back({OpJal, 26'h0123456});
        wordList.push_back(rType(FunctJr));
        wordList.push_back(rType(FunctJalr));
        runTest("jumps");

        for (int i = 0; i < 200; i++)
        begin
            word = $urandom();
            if ($urandom_range(2, 0) != 0)
                word[31:26] = 6'($urandom_range(43, 0)); // Covers every kept opcode
            if (word[31:26] == OpRtype && $urandom_range(1, 0) == 1)
                word[5:0] = AluFuncts[4'($urandom_range(15, 0))];
            if (word[31:26] == OpRegimm)
                word[20:16] = 5'($urandom_range(2, 0));
            wordList.push_back(word);
        end
        runTest("random mix");

        $display("Tests: %0d passed, %0d failed; checks: %0d, errors: %0d",
                 testsPassed, testsFailed, checkCount, errorCount);
        if (testsFailed == 0 && errorCount == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end
endmodule

// ==== verification/clockGen.sv ====
`timescale 1ns/10ps

module clockGen (
    output logic clk
);
    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end
endmodule

// ==== logic/mipsControl.sv ====
`timescale 1ns/10ps

module mipsControl (
    input  logic               clk,
    input  logic               rstN,
    input  isaPkg::instrT      instr,
    output ctrlPkg::stateT     state,
    output logic               pcWrite,
    output logic               pcWriteCond,
    output logic               irWrite,
    output logic               memRead,
    output logic               memWrite,
    output logic               regWrite,
    output logic               mdrWrite,
    output logic               iOrD,
    output ctrlPkg::aluOpT     aluOp,
    output ctrlPkg::srcASelT   srcA,
    output ctrlPkg::srcBSelT   srcB,
    output ctrlPkg::regDstT    regDst,
    output ctrlPkg::memToRegT  memToReg,
    output ctrlPkg::pcSrcT     pcSrc,
    output ctrlPkg::memRWidthT memRWidth,
    output ctrlPkg::memWWidthT memWWidth
);
    import ctrlPkg::*;

    stateT nextState;

    decodeIf decBus ();

    instrDecoder decoder_i (
        .clk       (clk),
        .rstN      (rstN),
        .instr     (instr),
        .nextState (nextState),
        .dec       (decBus.producer)
    );

    stateSequencer sequencer_i (
        .clk       (clk),
        .rstN      (rstN),
        .dec       (decBus.sequencer),
        .state     (state),
        .nextState (nextState)
    );

    controlEncoder encoder_i (
        .clk         (clk),
        .rstN        (rstN),
        .nextState   (nextState),
        .dec         (decBus.encoder),
        .pcWrite     (pcWrite),
        .pcWriteCond (pcWriteCond),
        .irWrite     (irWrite),
        .memRead     (memRead),
        .memWrite    (memWrite),
        .regWrite    (regWrite),
        .mdrWrite    (mdrWrite),
        .iOrD        (iOrD),
        .aluOp       (aluOp),
        .srcA        (srcA),
        .srcB        (srcB),
        .regDst      (regDst),
        .memToReg    (memToReg),
        .pcSrc       (pcSrc),
        .memRWidth   (memRWidth),
        .memWWidth   (memWWidth)
    );

endmodule

// ==== logic/controlEncoder.sv ====
`timescale 1ns/10ps

module controlEncoder (
    input  logic               clk,
    input  logic               rstN,
    input  ctrlPkg::stateT     nextState,
    decodeIf.encoder           dec,
    output logic               pcWrite,
    output logic               pcWriteCond,
    output logic               irWrite,
    output logic               memRead,
    output logic               memWrite,
    output logic               regWrite,
    output logic               mdrWrite,
    output logic               iOrD,
    output ctrlPkg::aluOpT     aluOp,
    output ctrlPkg::srcASelT   srcA,
    output ctrlPkg::srcBSelT   srcB,
    output ctrlPkg::regDstT    regDst,
    output ctrlPkg::memToRegT  memToReg,
    output ctrlPkg::pcSrcT     pcSrc,
    output ctrlPkg::memRWidthT memRWidth,
    output ctrlPkg::memWWidthT memWWidth
);
    import ctrlPkg::*;

    // Word for the state being entered, so it lines up with the state register
    always_ff @(posedge clk)
    begin
        pcWrite     <= 1'b0; // Inactive unless the entered state drives it
        pcWriteCond <= 1'b0;
        irWrite     <= 1'b0;
        memRead     <= 1'b0;
        memWrite    <= 1'b0;
        regWrite    <= 1'b0;
        mdrWrite    <= 1'b0;
        iOrD        <= 1'b0;
        aluOp       <= Add;
        srcA        <= SrcARegA;
        srcB        <= SrcBRegB;
        regDst      <= DstRt;
        memToReg    <= WbMemData;
        pcSrc       <= PcAluResult;
        memRWidth   <= RdNone;
        memWWidth   <= WrNone;
        if (rstN)
        begin
            case (nextState)
                Fetch:
                begin
                    pcWrite <= 1'b1;
                    irWrite <= 1'b1;
                    srcA    <= SrcAPc;
                    srcB    <= SrcBFour; // PC + 4
                end
                Decode:
                begin
                    srcA <= SrcAPc;
                    srcB <= SrcBBranchOff; // Branch target ahead of time
                end
                MemAddr: srcB <= SrcBSignImm;
                MemLoad:
                begin
                    iOrD      <= 1'b1;
                    memRead   <= 1'b1;
                    mdrWrite  <= 1'b1;
                    memRWidth <= dec.memRWidth;
                end
                MemStore:
                begin
                    iOrD      <= 1'b1;
                    memWrite  <= 1'b1;
                    memWWidth <= dec.memWWidth;
                end
                Execute:
                begin
                    aluOp <= dec.execAluOp;
                    srcA  <= dec.execSrcA;
                    srcB  <= dec.execSrcB;
                end
                AluWriteback:
                begin
                    regWrite <= 1'b1;
                    memToReg <= WbAluOut;
                    regDst   <= dec.wbDst;
                end
                Branch:
                begin
                    pcWriteCond <= 1'b1;
                    aluOp       <= dec.branchAluOp;
                    pcSrc       <= PcBranchTarget;
                end
                Jump:
                begin
                    pcWrite <= 1'b1;
                    pcSrc   <= dec.jumpPcSrc;
                    if (dec.link)
                    begin
                        regWrite <= 1'b1; // PC + 4 into the link register
                        regDst   <= DstLink;
                        memToReg <= WbPcPlus4;
                    end
                end
                LoadWriteback: regWrite <= 1'b1;
                default: ;
            endcase
        end
    end

    noReadWithWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(memRead && memWrite));

    noDoublePcWrite: assert property (@(posedge clk) disable iff (!rstN)
        !(pcWrite && pcWriteCond));

endmodule

// ==== logic/stateSequencer.sv ====
`timescale 1ns/10ps

module stateSequencer (
    input  logic           clk,
    input  logic           rstN,
    decodeIf.sequencer     dec,
    output ctrlPkg::stateT state,
    output ctrlPkg::stateT nextState
);
    import ctrlPkg::*;

    always_ff @(posedge clk)
    begin
        if (!rstN)
            state <= Initial;
        else
            state <= nextState;
    end

    always_comb
    begin
        nextState = Initial;
        case (state)
            Initial: nextState = Fetch;
            Fetch:   nextState = Decode;
            Decode:
            begin
                case (dec.instrClass)
                    ClassAlu:               nextState = Execute;
                    ClassLoad, ClassStore:  nextState = MemAddr;
                    ClassBranch:            nextState = Branch;
                    ClassJump:              nextState = Jump;
                    default:                nextState = Initial; // Unknown encoding
                endcase
            end
            MemAddr:
            begin
                if (dec.instrClass == ClassLoad)
                    nextState = MemLoad;
                else if (dec.instrClass == ClassStore)
                    nextState = MemStore;
                else
                    nextState = Initial;
            end
            MemLoad:       nextState = LoadWriteback;
            Execute:       nextState = AluWriteback;
            MemStore, AluWriteback, Branch, Jump, LoadWriteback:
                nextState = Fetch;
            default:       nextState = Initial;
        endcase
    end

    initialToFetch: assert property (@(posedge clk) disable iff (!rstN)
        state == Initial |=> state == Fetch);

    fetchToDecode: assert property (@(posedge clk) disable iff (!rstN)
        state == Fetch |=> state == Decode);

endmodule

// ==== logic/instrDecoder.sv ====
`timescale 1ns/10ps

module instrDecoder (
    input  logic           clk,
    input  logic           rstN,
    input  isaPkg::instrT  instr,
    input  ctrlPkg::stateT nextState,
    decodeIf.producer      dec
);
    import isaPkg::*;
    import ctrlPkg::*;

    instrT  instrReg;
    opcodeT opcode;
    functT  funct;
    regIdxT rt;
    logic   keptInstr;

    // Stands in for the datapath instruction register
    always_ff @(posedge clk)
    begin
        if (nextState == Fetch)
            instrReg <= instr;
    end

    assign opcode = instrReg[31:26];
    assign rt     = instrReg[20:16];
    assign funct  = instrReg[5:0];

    always_comb
    begin
        dec.instrClass  = ClassIllegal;
        dec.execAluOp   = Add;
        dec.execSrcA    = SrcARegA;
        dec.execSrcB    = SrcBSignImm;
        dec.branchAluOp = Sub;
        dec.wbDst       = DstRt;
        dec.memRWidth   = RdNone;
        dec.memWWidth   = WrNone;
        dec.jumpPcSrc   = PcJumpTarget;
        dec.link        = 1'b0;
        case (opcode)
            OpRtype:
            begin
                dec.instrClass = ClassAlu;
                dec.execSrcB   = SrcBRegB;
                dec.wbDst      = DstRd;
                case (funct)
                    FunctAdd, FunctAddu: dec.execAluOp = Add;
                    FunctSub, FunctSubu: dec.execAluOp = Sub;
                    FunctAnd:            dec.execAluOp = And;
                    FunctOr:             dec.execAluOp = Or;
                    FunctXor:            dec.execAluOp = Xor;
                    FunctNor:            dec.execAluOp = Nor;
                    FunctSlt:            dec.execAluOp = Slt;
                    FunctSltu:           dec.execAluOp = Sltu;
                    FunctSllv:           dec.execAluOp = Sll;
                    FunctSrlv:           dec.execAluOp = Srl;
                    FunctSrav:           dec.execAluOp = Sra;
                    FunctSll:
                    begin
                        dec.execAluOp = Sll;
                        dec.execSrcA  = SrcAShamt;
                    end
                    FunctSrl:
                    begin
                        dec.execAluOp = Srl;
                        dec.execSrcA  = SrcAShamt;
                    end
                    FunctSra:
                    begin
                        dec.execAluOp = Sra;
                        dec.execSrcA  = SrcAShamt;
                    end
                    FunctJr, FunctJalr:
                    begin
                        dec.instrClass = ClassJump;
                        dec.jumpPcSrc  = PcRegister;
                        dec.link       = (funct == FunctJalr);
                    end
                    default: dec.instrClass = ClassIllegal;
                endcase
            end
            OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri, OpXori, OpLui:
            begin
                dec.instrClass = ClassAlu;
                case (opcode)
                    OpSlti:  dec.execAluOp = Slt;
                    OpSltiu: dec.execAluOp = Sltu;
                    OpAndi:  dec.execAluOp = AndI;
                    OpOri:   dec.execAluOp = OrI;
                    OpXori:  dec.execAluOp = XorI;
                    OpLui:   dec.execAluOp = Lui;
                    default: dec.execAluOp = Add; // addi, addiu
                endcase
            end
            OpLw:  {dec.instrClass, dec.memRWidth} = {ClassLoad, RdWord};
            OpLh:  {dec.instrClass, dec.memRWidth} = {ClassLoad, RdHalf};
            OpLhu: {dec.instrClass, dec.memRWidth} = {ClassLoad, RdHalfU};
            OpLb:  {dec.instrClass, dec.memRWidth} = {ClassLoad, RdByte};
            OpLbu: {dec.instrClass, dec.memRWidth} = {ClassLoad, RdByteU};
            OpSw:  {dec.instrClass, dec.memWWidth} = {ClassStore, WrWord};
            OpSh:  {dec.instrClass, dec.memWWidth} = {ClassStore, WrHalf};
            OpSb:  {dec.instrClass, dec.memWWidth} = {ClassStore, WrByte};
            OpBeq:  {dec.instrClass, dec.branchAluOp} = {ClassBranch, Sub};
            OpBne:  {dec.instrClass, dec.branchAluOp} = {ClassBranch, Bne};
            OpBlez: {dec.instrClass, dec.branchAluOp} = {ClassBranch, Blez};
            OpBgtz: {dec.instrClass, dec.branchAluOp} = {ClassBranch, Bgtz};
            OpRegimm:
            begin
                if (rt == RtBltz)
                    {dec.instrClass, dec.branchAluOp} = {ClassBranch, Bltz};
                else if (rt == RtBgez)
                    {dec.instrClass, dec.branchAluOp} = {ClassBranch, Bgez};
            end
            OpJ, OpJal:
            begin
                dec.instrClass = ClassJump;
                dec.link       = (opcode == OpJal);
            end
            default: dec.instrClass = ClassIllegal;
        endcase
    end

    // Independent list of everything the unit supports
    assign keptInstr = (opcode inside {OpJ, OpJal, OpBeq, OpBne, OpBlez, OpBgtz,
                                       OpAddi, OpAddiu, OpSlti, OpSltiu, OpAndi, OpOri,
                                       OpXori, OpLui, OpLb, OpLh, OpLw, OpLbu, OpLhu,
                                       OpSb, OpSh, OpSw})
                     || (opcode == OpRegimm && rt inside {RtBltz, RtBgez})
                     || (opcode == OpRtype && funct inside {FunctSll, FunctSrl, FunctSra,
                            FunctSllv, FunctSrlv, FunctSrav, FunctJr, FunctJalr,
                            FunctAdd, FunctAddu, FunctSub, FunctSubu, FunctAnd, FunctOr,
                            FunctXor, FunctNor, FunctSlt, FunctSltu});

    keptNotIllegal: assert property (@(posedge clk) disable iff (!rstN)
        (nextState == Decode && keptInstr) |-> dec.instrClass != ClassIllegal);

endmodule

// ==== logic/decodeIf.sv ====
`timescale 1ns/10ps

interface decodeIf;
    import ctrlPkg::*;

    instrClassT instrClass;
    aluOpT      execAluOp;
    srcASelT    execSrcA;
    srcBSelT    execSrcB;
    aluOpT      branchAluOp;
    regDstT     wbDst; // rd for register type, rt otherwise
    memRWidthT  memRWidth;
    memWWidthT  memWWidth;
    pcSrcT      jumpPcSrc;
    logic       link; // jal or jalr

    modport producer (output instrClass, execAluOp, execSrcA, execSrcB, branchAluOp,
                      wbDst, memRWidth, memWWidth, jumpPcSrc, link);
    modport sequencer (input instrClass);
    modport encoder (input execAluOp, execSrcA, execSrcB, branchAluOp,
                     wbDst, memRWidth, memWWidth, jumpPcSrc, link);
endinterface

// ==== logic/ctrlPkg.sv ====
package ctrlPkg;

    typedef enum logic [3:0] {
        Initial,
        Fetch,
        Decode,
        MemAddr,
        MemLoad,
        MemStore,
        Execute,
        AluWriteback,
        Branch,
        Jump,
        LoadWriteback
    } stateT;

    typedef enum logic [2:0] {
        ClassAlu,
        ClassLoad,
        ClassStore,
        ClassBranch,
        ClassJump,
        ClassIllegal
    } instrClassT;

    typedef enum logic [4:0] {
        Add, Sub, And, Or, Xor, Nor, Slt, Sltu, Sll, Srl, Sra,
        Lui, AndI, OrI, XorI, Bltz, Bgez, Bgtz, Blez, Bne
    } aluOpT;

    typedef enum logic [1:0] {
        SrcARegA,
        SrcAPc,
        SrcAShamt
    } srcASelT;

    typedef enum logic [1:0] {
        SrcBRegB,
        SrcBFour,
        SrcBSignImm,
        SrcBBranchOff // Sign-extended offset shifted by 2
    } srcBSelT;

    typedef enum logic [1:0] {
        DstRt,
        DstRd,
        DstLink
    } regDstT;

    typedef enum logic [1:0] {
        WbMemData,
        WbAluOut,
        WbPcPlus4
    } memToRegT;

    typedef enum logic [1:0] {
        PcAluResult,
        PcBranchTarget,
        PcJumpTarget,
        PcRegister
    } pcSrcT;

    typedef enum logic [2:0] {
        RdNone, RdWord, RdHalf, RdHalfU, RdByte, RdByteU
    } memRWidthT;

    typedef enum logic [1:0] {
        WrNone, WrWord, WrHalf, WrByte
    } memWWidthT;

endpackage

// ==== logic/isaPkg.sv ====
package isaPkg;

    typedef logic [31:0] instrT;
    typedef logic [5:0]  opcodeT;
    typedef logic [5:0]  functT;
    typedef logic [4:0]  regIdxT;

    // Primary opcodes
    localparam opcodeT OpRtype  = 6'h00;
    localparam opcodeT OpRegimm = 6'h01; // bltz and bgez, chosen by rt
    localparam opcodeT OpJ      = 6'h02;
    localparam opcodeT OpJal    = 6'h03;
    localparam opcodeT OpBeq    = 6'h04;
    localparam opcodeT OpBne    = 6'h05;
    localparam opcodeT OpBlez   = 6'h06;
    localparam opcodeT OpBgtz   = 6'h07;
    localparam opcodeT OpAddi   = 6'h08;
    localparam opcodeT OpAddiu  = 6'h09;
    localparam opcodeT OpSlti   = 6'h0a;
    localparam opcodeT OpSltiu  = 6'h0b;
    localparam opcodeT OpAndi   = 6'h0c;
    localparam opcodeT OpOri    = 6'h0d;
    localparam opcodeT OpXori   = 6'h0e;
    localparam opcodeT OpLui    = 6'h0f;
    localparam opcodeT OpLb     = 6'h20;
    localparam opcodeT OpLh     = 6'h21;
    localparam opcodeT OpLw     = 6'h23;
    localparam opcodeT OpLbu    = 6'h24;
    localparam opcodeT OpLhu    = 6'h25;
    localparam opcodeT OpSb     = 6'h28;
    localparam opcodeT OpSh     = 6'h29;
    localparam opcodeT OpSw     = 6'h2b;

    // Register-type function codes
    localparam functT FunctSll  = 6'h00;
    localparam functT FunctSrl  = 6'h02;
    localparam functT FunctSra  = 6'h03;
    localparam functT FunctSllv = 6'h04;
    localparam functT FunctSrlv = 6'h06;
    localparam functT FunctSrav = 6'h07;
    localparam functT FunctJr   = 6'h08;
    localparam functT FunctJalr = 6'h09;
    localparam functT FunctAdd  = 6'h20;
    localparam functT FunctAddu = 6'h21;
    localparam functT FunctSub  = 6'h22;
    localparam functT FunctSubu = 6'h23;
    localparam functT FunctAnd  = 6'h24;
    localparam functT FunctOr   = 6'h25;
    localparam functT FunctXor  = 6'h26;
    localparam functT FunctNor  = 6'h27;
    localparam functT FunctSlt  = 6'h2a;
    localparam functT FunctSltu = 6'h2b;

    localparam regIdxT RtBltz  = 5'd0;
    localparam regIdxT RtBgez  = 5'd1;
    localparam regIdxT LinkReg = 5'd31; // Return address register

endpackage
